//--- hw/cdbus_rx_pkg.sv
package cdbus_rx_pkg;

    // serial timing
    localparam int BIT_CLKS  = 8;       // clk cycles per bit
    localparam int IDLE_BITS = 12;      // high bit times until the bus counts as idle

    // frame format
    localparam logic [7:0] BROADCAST_ADDR = 8'hff;
    localparam int         FRAME_OVERHEAD = 5;    // src, dst, len, crc_l, crc_h

    // frame ram
    localparam int PAGE_DEPTH = 256;

    // crc16, modbus flavour
    localparam logic [15:0] CRC_INIT = 16'hffff;
    localparam logic [15:0] CRC_POLY = 16'ha001;  // reflected 0x8005

    typedef enum logic [1:0] {
        IDLE_WAIT,      // line high, looking for a start edge
        START,          // run to the middle of the start bit
        DATA_BITS,
        STOP
    } des_state_t;

    typedef enum logic {
        INIT,
        DATA
    } frame_state_t;

    // fold one byte into the running crc, lsb first
    function automatic logic [15:0] crc16_step(input logic [15:0] crc,
                                               input logic [7:0]  data);
        logic [15:0] c;
        int          i;
        c = crc ^ {8'h00, data};
        for (i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

//--- hw/cdbus_rx_ifs.sv
`timescale 1ns/1ns

// character stream from the deserializer to the frame checker
interface des_if;
    logic        bus_idle;
    logic [7:0]  data;
    logic [15:0] crc_data;          // crc including the byte in data
    logic        data_clk;          // one cycle per new byte
    logic        force_wait_idle;   // drop characters until next idle

    modport des (
        output bus_idle, data, crc_data, data_clk,
        input  force_wait_idle
    );

    modport bytes (
        input  bus_idle, data, crc_data, data_clk,
        output force_wait_idle
    );
endinterface

// write port into the ping-pong frame ram
interface ram_wr_if;
    logic [7:0] wr_byte;
    logic [7:0] wr_addr;
    logic       wr_clk;     // write strobe
    logic [7:0] wr_flags;
    logic       switch;     // close the current page with wr_flags

    modport wr (
        output wr_byte, wr_addr, wr_clk, wr_flags, switch
    );

    modport ram (
        input  wr_byte, wr_addr, wr_clk, wr_flags, switch
    );
endinterface

//--- hw/rx_des.sv
`timescale 1ns/1ns

module rx_des import cdbus_rx_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    input  logic rx,
    des_if.des   des
);

    logic [1:0] rx_sync;
    logic       rx_s;           // synchronised line
    des_state_t state;
    logic [3:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic [7:0] idle_cnt;
    logic       hold;           // waiting for idle, characters are swallowed
    logic       bit_tick;
    logic       stop_ok;

    assign rx_s     = rx_sync[1];
    assign bit_tick = (clk_cnt == 4'(BIT_CLKS - 1));

    // good stop bit and nobody asked us to hold off
    assign stop_ok = (state == STOP) && bit_tick && rx_s && !hold;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rx_sync <= 2'b11;   // line idles high
        else
            rx_sync <= {rx_sync[0], rx};
    end

    // bit sampler
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= IDLE_WAIT;
            clk_cnt <= '0;
            bit_idx <= '0;
        end
        else begin
            case (state)
                IDLE_WAIT: begin
                    clk_cnt <= '0;
                    if (!rx_s)
                        state <= START;
                end

                START: begin
                    if (clk_cnt == 4'(BIT_CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a high line here was only a glitch
                        state <= rx_s ? IDLE_WAIT : DATA_BITS;
                    end
                    else begin
                        clk_cnt <= clk_cnt + 4'd1;
                    end
                end

                DATA_BITS: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= STOP;
                    end
                    else begin
                        clk_cnt <= clk_cnt + 4'd1;
                    end
                end

                STOP: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        state   <= IDLE_WAIT;   // framing error just drops the char
                    end
                    else begin
                        clk_cnt <= clk_cnt + 4'd1;
                    end
                end

                default: state <= IDLE_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA_BITS && bit_tick)
            shift <= {rx_s, shift[7:1]};    // lsb first
        if (stop_ok)
            des.data <= shift;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            des.data_clk <= 1'b0;
            des.crc_data <= CRC_INIT;
        end
        else begin
            des.data_clk <= stop_ok;
            if (des.bus_idle)
                des.crc_data <= CRC_INIT;
            else if (stop_ok)
                des.crc_data <= crc16_step(des.crc_data, shift);
        end
    end

    // idle detector, counts clk cycles of continuous high line
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_cnt     <= '0;
            des.bus_idle <= 1'b0;
        end
        else if (!rx_s) begin
            idle_cnt     <= '0;
            des.bus_idle <= 1'b0;
        end
        else if (idle_cnt == 8'(IDLE_BITS * BIT_CLKS - 1)) begin
            des.bus_idle <= 1'b1;
        end
        else begin
            idle_cnt <= idle_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            hold <= 1'b0;
        else if (des.force_wait_idle)
            hold <= 1'b1;
        else if (des.bus_idle)
            hold <= 1'b0;
    end

endmodule

//--- hw/rx_bytes.sv
`timescale 1ns/1ns

module rx_bytes import cdbus_rx_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] filter,
    input  logic       user_crc,
    input  logic       not_drop,
    input  logic       abort,
    output logic       error,       // bad crc or truncated frame
    des_if.bytes       des,
    ram_wr_if.wr       ram
);

    frame_state_t state;
    logic [8:0]   byte_cnt;         // index of the incoming byte
    logic [7:0]   data_len;         // copy of the len byte
    logic [8:0]   rx_len;
    logic [8:0]   last_idx;
    logic         drop_flag;
    logic         finish;
    logic         is_promiscuous;

    assign ram.wr_byte = des.data;  // held stable until the next char
    assign rx_len      = byte_cnt + 9'd1;
    assign last_idx    = {1'b0, data_len} + 9'(FRAME_OVERHEAD - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state               <= INIT;
            des.force_wait_idle <= 1'b0;
        end
        else begin
            des.force_wait_idle <= 1'b0;

            case (state)
                INIT: begin
                    // joined mid-frame, skip the rest of it
                    if (!des.bus_idle)
                        des.force_wait_idle <= 1'b1;
                    state <= DATA;
                end

                DATA: begin
                    if (finish)
                        state <= INIT;
                end

                default: state <= INIT;
            endcase

            if (abort)
                state <= INIT;
        end
    end

    // frame layout: src, dst, len, data..., crc_l, crc_h
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error          <= 1'b0;
            ram.wr_addr    <= '0;
            ram.wr_clk     <= 1'b0;
            ram.wr_flags   <= '0;
            ram.switch     <= 1'b0;
            byte_cnt       <= '0;
            data_len       <= '0;
            drop_flag      <= 1'b0;
            finish         <= 1'b0;
            is_promiscuous <= 1'b0;
        end
        else begin
            error          <= 1'b0;
            ram.wr_clk     <= 1'b0;
            ram.switch     <= 1'b0;
            finish         <= 1'b0;
            is_promiscuous <= (filter == BROADCAST_ADDR);

            if (state == INIT) begin
                byte_cnt  <= '0;
                data_len  <= '0;
                drop_flag <= 1'b0;
            end
            else begin
                if (des.bus_idle) begin
                    if (byte_cnt != 9'd0) begin
                        // went idle before the last byte
                        if (byte_cnt != 9'd1 && !drop_flag) begin
                            error <= 1'b1;
                            if (not_drop) begin
                                ram.wr_flags <= ram.wr_addr;
                                ram.switch   <= 1'b1;
                            end
                        end
                        finish    <= 1'b1;
                        drop_flag <= 1'b1;  // only one switch per frame
                    end
                end
                else if (des.data_clk) begin
                    if (byte_cnt < 9'(PAGE_DEPTH)) begin
                        ram.wr_addr <= byte_cnt[7:0];
                        ram.wr_clk  <= 1'b1;
                    end

                    if (byte_cnt == 9'd0 && des.data == filter)
                        drop_flag <= ~is_promiscuous;     // our own echo

                    if (byte_cnt == 9'd1 && des.data != filter
                            && des.data != BROADCAST_ADDR)
                        drop_flag <= ~is_promiscuous;     // someone else's frame

                    if (byte_cnt == 9'd2)
                        data_len <= des.data;

                    if (byte_cnt == last_idx) begin
                        if (!drop_flag) begin
                            if (des.crc_data == 16'h0000 || user_crc) begin
                                ram.wr_flags <= 8'h00;
                                ram.switch   <= 1'b1;
                            end
                            else begin
                                error <= 1'b1;
                                if (not_drop) begin
                                    // flags carry the byte count
                                    ram.wr_flags <= rx_len[8] ? 8'hff : rx_len[7:0];
                                    ram.switch   <= 1'b1;
                                end
                            end
                        end
                        finish <= 1'b1;
                    end

                    byte_cnt <= rx_len;
                end

                if (abort) begin
                    error      <= 1'b0;
                    ram.switch <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/rx_pp_ram.sv
`timescale 1ns/1ns

module rx_pp_ram import cdbus_rx_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    ram_wr_if.ram      ram,
    input  logic [7:0] rd_addr,
    output logic [7:0] rd_byte,
    output logic [7:0] rd_flags,
    output logic       rx_pending,
    input  logic       rx_release,
    output logic       rx_lost
);

    logic [7:0] page0 [PAGE_DEPTH];
    logic [7:0] page1 [PAGE_DEPTH];
    logic [7:0] page_flags [2];
    logic [1:0] full;           // page holds a closed frame
    logic       wr_page;
    logic       rd_page;        // oldest full page
    logic       wr_ok;

    // a full write page means both are taken, writes are dropped
    assign wr_ok = !full[wr_page];

    assign rx_pending = full[rd_page];
    assign rd_flags   = page_flags[rd_page];

    always_ff @(posedge clk) begin
        if (ram.wr_clk && wr_ok) begin
            if (wr_page)
                page1[ram.wr_addr] <= ram.wr_byte;
            else
                page0[ram.wr_addr] <= ram.wr_byte;
        end
        if (ram.switch && wr_ok)
            page_flags[wr_page] <= ram.wr_flags;
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_byte <= rd_page ? page1[rd_addr] : page0[rd_addr];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full    <= 2'b00;
            wr_page <= 1'b0;
            rd_page <= 1'b0;
            rx_lost <= 1'b0;
        end
        else begin
            rx_lost <= 1'b0;

            if (ram.switch) begin
                if (wr_ok) begin
                    full[wr_page] <= 1'b1;
                    wr_page       <= ~wr_page;
                end
                else begin
                    rx_lost <= 1'b1;    // frame discarded
                end
            end

            // pages fill in turn, so the next oldest is the other one
            if (rx_release && full[rd_page]) begin
                full[rd_page] <= 1'b0;
                rd_page       <= ~rd_page;
            end
        end
    end

endmodule

//--- hw/cdbus_rx.sv
`timescale 1ns/1ns

module cdbus_rx (
    input  logic       clk,
    input  logic       reset_n,

    input  logic       rx,          // serial line, idle high

    // host control
    input  logic [7:0] filter,
    input  logic       user_crc,
    input  logic       not_drop,
    input  logic       abort,
    output logic       error,

    // host read side
    input  logic [7:0] rd_addr,
    output logic [7:0] rd_byte,
    output logic [7:0] rd_flags,
    output logic       rx_pending,
    input  logic       rx_release,
    output logic       rx_lost
);

    des_if    des_bus ();
    ram_wr_if ram_wr ();

    rx_des i_rx_des (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx         (rx),
        .des        (des_bus.des)
    );

    rx_bytes i_rx_bytes (
        .clk        (clk),
        .reset_n    (reset_n),
        .filter     (filter),
        .user_crc   (user_crc),
        .not_drop   (not_drop),
        .abort      (abort),
        .error      (error),
        .des        (des_bus.bytes),
        .ram        (ram_wr.wr)
    );

    rx_pp_ram i_rx_pp_ram (
        .clk        (clk),
        .reset_n    (reset_n),
        .ram        (ram_wr.ram),
        .rd_addr    (rd_addr),
        .rd_byte    (rd_byte),
        .rd_flags   (rd_flags),
        .rx_pending (rx_pending),
        .rx_release (rx_release),
        .rx_lost    (rx_lost)
    );

endmodule

//--- tb/cdbus_rx_checker.sv
`timescale 1ns/1ns

module cdbus_rx_checker (
    input  logic       clk,

    // watched dut outputs
    input  logic       error,
    input  logic       rx_pending,
    input  logic       rx_lost,
    input  logic [7:0] rd_flags,
    input  logic [7:0] rd_addr,
    input  logic [7:0] rd_byte,

    // expectations of the current table entry
    input  int         entry_idx,
    input  logic       frame_start,     // clears the pulse counters
    input  logic       frame_check,
    input  logic       exp_pending,
    input  logic [7:0] exp_flags,
    input  logic [1:0] exp_errors,
    input  logic       exp_lost,
    input  logic       byte_check,
    input  logic [7:0] exp_byte,

    output int         err_count,
    output int         check_count
);

    int error_pulses;
    int lost_pulses;

    initial begin
        err_count    = 0;
        check_count  = 0;
        error_pulses = 0;
        lost_pulses  = 0;
    end

    task automatic mismatch(input string what, input logic [15:0] got,
                            input logic [15:0] want);
        err_count++;
        $display("ERROR %0t: entry %0d %s is %0h, expected %0h",
                 $time, entry_idx, what, got, want);
    endtask

    always @(posedge clk) begin
        if (frame_start) begin
            error_pulses = 0;
            lost_pulses  = 0;
        end
        else begin
            if (error)
                error_pulses++;
            if (rx_lost)
                lost_pulses++;
        end

        if (frame_check) begin
            check_count++;
            if (rx_pending !== exp_pending)
                mismatch("rx_pending", 16'(rx_pending), 16'(exp_pending));
            else if (exp_pending && rd_flags !== exp_flags)
                mismatch("rd_flags", 16'(rd_flags), 16'(exp_flags));
            if (error_pulses != exp_errors)
                mismatch("error pulse count", 16'(error_pulses), 16'(exp_errors));
            if (lost_pulses != exp_lost)
                mismatch("rx_lost pulse count", 16'(lost_pulses), 16'(exp_lost));
        end

        if (byte_check) begin
            check_count++;
            if (rd_byte !== exp_byte) begin
                err_count++;
                $display("ERROR %0t: entry %0d byte at address %0h reads %0h, expected %0h",
                         $time, entry_idx, rd_addr, rd_byte, exp_byte);
            end
        end
    end

endmodule

//--- tb/tb_cdbus_rx.sv
`timescale 1ns/1ns

module tb_cdbus_rx import cdbus_rx_pkg::*; ();

    localparam int NUM_ENTRIES = 15;
    localparam int MAX_LEN     = 9;
    localparam int GAP_BITS    = IDLE_BITS + 2;
    // frames x (bytes + idle) x 10 bits x bit time, doubled
    localparam int TIMEOUT_NS  = NUM_ENTRIES * (MAX_LEN + FRAME_OVERHEAD + GAP_BITS)
                                 * 10 * BIT_CLKS * 8 * 2;

    typedef struct packed {
        logic [7:0] filter;
        logic       user_crc;
        logic       not_drop;
        logic [7:0] src;
        logic [7:0] dst;
        logic [7:0] len;
        logic       corrupt;        // flip bit 0 of crc_l
        logic [7:0] trunc;          // bytes sent, 0 means whole frame
        logic       keep;           // page stays until the final drain
        logic       exp_pending;
        logic [7:0] exp_flags;
        logic [1:0] exp_errors;
        logic       exp_lost;
    } entry_t;

    logic       clk;
    logic       reset_n;
    logic       rx;
    logic [7:0] filter;
    logic       user_crc;
    logic       not_drop;
    logic       abort;
    logic       error;
    logic [7:0] rd_addr;
    logic [7:0] rd_byte;
    logic [7:0] rd_flags;
    logic       rx_pending;
    logic       rx_release;
    logic       rx_lost;

    // checker side
    int         cur_entry;
    logic       frame_start;
    logic       frame_check;
    logic       exp_pending;
    logic [7:0] exp_flags;
    logic [1:0] exp_errors;
    logic       exp_lost;
    logic       byte_check;
    logic [7:0] exp_byte;
    int         err_count;
    int         check_count;

    entry_t     frames [NUM_ENTRIES];
    logic [7:0] sent [NUM_ENTRIES][32];     // bytes as they went out on the line
    int         sent_cnt [NUM_ENTRIES];
    int         held_q [$];
    integer     seed;

    cdbus_rx i_cdbus_rx (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx         (rx),
        .filter     (filter),
        .user_crc   (user_crc),
        .not_drop   (not_drop),
        .abort      (abort),
        .error      (error),
        .rd_addr    (rd_addr),
        .rd_byte    (rd_byte),
        .rd_flags   (rd_flags),
        .rx_pending (rx_pending),
        .rx_release (rx_release),
        .rx_lost    (rx_lost)
    );

    cdbus_rx_checker i_cdbus_rx_checker (
        .clk         (clk),
        .error       (error),
        .rx_pending  (rx_pending),
        .rx_lost     (rx_lost),
        .rd_flags    (rd_flags),
        .rd_addr     (rd_addr),
        .rd_byte     (rd_byte),
        .entry_idx   (cur_entry),
        .frame_start (frame_start),
        .frame_check (frame_check),
        .exp_pending (exp_pending),
        .exp_flags   (exp_flags),
        .exp_errors  (exp_errors),
        .exp_lost    (exp_lost),
        .byte_check  (byte_check),
        .exp_byte    (exp_byte),
        .err_count   (err_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // modbus crc, one bit at a time through the lfsr
    function automatic logic [15:0] crc_add_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        int          i;
        c = crc;
        for (i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = c >> 1;
            if (fb)
                c = c ^ 16'ha001;
        end
        return c;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic set_entry(input int idx, input logic [7:0] flt, input logic ucrc,
                             input logic nd, input logic [7:0] src, input logic [7:0] dst,
                             input logic [7:0] len, input logic bad, input logic [7:0] trunc,
                             input logic keep, input logic pend, input logic [7:0] flags,
                             input logic [1:0] errs, input logic lost);
        frames[idx] = {flt, ucrc, nd, src, dst, len, bad, trunc,
                       keep, pend, flags, errs, lost};
    endtask

    task automatic load_frames();
        //        flt    uc nd src    dst    len bad trn kp pd flags  er lost
        set_entry(0,  8'h21, 0, 0, 8'h05, 8'h21, 6, 0, 0, 0, 1, 8'h00, 0, 0);
        set_entry(1,  8'h21, 0, 0, 8'h05, 8'hff, 3, 0, 0, 0, 1, 8'h00, 0, 0);
        set_entry(2,  8'h21, 0, 0, 8'h05, 8'h33, 4, 0, 0, 0, 0, 8'h00, 0, 0);  // other node
        set_entry(3,  8'h21, 0, 0, 8'h21, 8'hff, 4, 0, 0, 0, 0, 8'h00, 0, 0);  // own echo
        set_entry(4,  8'hff, 0, 0, 8'h05, 8'h33, 4, 0, 0, 0, 1, 8'h00, 0, 0);
        set_entry(5,  8'hff, 0, 0, 8'hff, 8'h33, 2, 0, 0, 0, 1, 8'h00, 0, 0);
        set_entry(6,  8'h21, 0, 0, 8'h05, 8'h21, 5, 1, 0, 0, 0, 8'h00, 1, 0);
        set_entry(7,  8'h21, 0, 1, 8'h05, 8'h21, 5, 1, 0, 0, 1, 8'h0a, 1, 0);  // flags len+5
        set_entry(8,  8'h21, 1, 0, 8'h05, 8'h21, 5, 1, 0, 0, 1, 8'h00, 0, 0);
        set_entry(9,  8'h21, 0, 0, 8'h05, 8'h21, 8, 0, 6, 0, 0, 8'h00, 1, 0);
        set_entry(10, 8'h21, 0, 1, 8'h05, 8'h21, 8, 0, 6, 0, 1, 8'h05, 1, 0);  // flags k-1
        set_entry(11, 8'h21, 0, 1, 8'h05, 8'h21, 8, 0, 2, 0, 1, 8'h01, 1, 0);
        // both pages taken, then one too many
        set_entry(12, 8'h21, 0, 0, 8'h05, 8'h21, 7, 0, 0, 1, 1, 8'h00, 0, 0);
        set_entry(13, 8'h21, 0, 0, 8'h05, 8'hff, 9, 0, 0, 1, 1, 8'h00, 0, 0);
        set_entry(14, 8'h21, 0, 0, 8'h05, 8'h21, 4, 0, 0, 1, 1, 8'h00, 0, 1);
    endtask

    task automatic build_frame(input int e);
        logic [15:0] crc;
        logic [31:0] rnd;
        int          n;
        int          i;
        n = frames[e].len + 3;
        sent[e][0] = frames[e].src;
        sent[e][1] = frames[e].dst;
        sent[e][2] = frames[e].len;
        for (i = 3; i < n; i++) begin
            rnd        = $random(seed);
            sent[e][i] = rnd[7:0];
        end
        crc = 16'hffff;
        for (i = 0; i < n; i++)
            crc = crc_add_byte(crc, sent[e][i]);
        sent[e][n]     = crc[7:0] ^ {7'd0, frames[e].corrupt};     // low byte first
        sent[e][n + 1] = crc[15:8];
        sent_cnt[e]    = (frames[e].trunc != 0) ? frames[e].trunc : n + 2;
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] b);
        int i;
        rx = 1'b0;
        tick(BIT_CLKS);
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            tick(BIT_CLKS);
        end
        rx = 1'b1;
        tick(BIT_CLKS);
    endtask

    task automatic read_page(input int e);
        int a;
        for (a = 0; a < sent_cnt[e]; a++) begin
            rd_addr = a[7:0];
            tick(1);                // rd_byte valid after one cycle
            exp_byte   = sent[e][a];
            byte_check = 1'b1;
            tick(1);
            byte_check = 1'b0;
        end
    endtask

    task automatic release_page();
        rx_release = 1'b1;
        tick(1);
        rx_release = 1'b0;
        tick(1);
    endtask

    // fresh pulse counts, then one status check
    task automatic check_state();
        frame_start = 1'b1;
        tick(1);
        frame_start = 1'b0;
        frame_check = 1'b1;
        tick(1);
        frame_check = 1'b0;
    endtask

    task automatic run_entry(input int e);
        int i;
        int n;
        cur_entry   = e;
        filter      = frames[e].filter;
        user_crc    = frames[e].user_crc;
        not_drop    = frames[e].not_drop;
        exp_pending = frames[e].exp_pending;
        exp_flags   = frames[e].exp_flags;
        exp_errors  = frames[e].exp_errors;
        exp_lost    = frames[e].exp_lost;
        build_frame(e);
        frame_start = 1'b1;
        tick(1);
        frame_start = 1'b0;
        for (i = 0; i < sent_cnt[e]; i++)
            send_byte(sent[e][i]);
        tick(GAP_BITS * BIT_CLKS);
        // bounded wait for the pending level
        for (n = 0; n < 4 * BIT_CLKS && exp_pending && !rx_pending; n++)
            tick(1);
        frame_check = 1'b1;
        tick(1);
        frame_check = 1'b0;
        if (frames[e].keep) begin
            if (!frames[e].exp_lost)
                held_q.push_back(e);
        end
        else begin
            if (frames[e].exp_pending)
                read_page(e);
            if (rx_pending)
                release_page();
        end
    endtask

    // held pages come out oldest first, each shown with its own flags
    task automatic drain_held();
        int e;
        while (held_q.size() > 0) begin
            e           = held_q.pop_front();
            cur_entry   = e;
            exp_pending = 1'b1;
            exp_flags   = frames[e].exp_flags;
            exp_errors  = 2'd0;
            exp_lost    = 1'b0;
            check_state();
            read_page(e);
            release_page();
        end
        cur_entry   = NUM_ENTRIES;
        exp_pending = 1'b0;
        exp_errors  = 2'd0;
        exp_lost    = 1'b0;
        check_state();
    endtask

    initial begin
        int e;
        seed        = 32'h92cbf4e0;
        reset_n     = 1'b0;
        rx          = 1'b1;
        filter      = 8'h00;
        user_crc    = 1'b0;
        not_drop    = 1'b0;
        abort       = 1'b0;
        rd_addr     = 8'h00;
        rx_release  = 1'b0;
        cur_entry   = 0;
        frame_start = 1'b0;
        frame_check = 1'b0;
        exp_pending = 1'b0;
        exp_flags   = 8'h00;
        exp_errors  = 2'd0;
        exp_lost    = 1'b0;
        byte_check  = 1'b0;
        exp_byte    = 8'h00;
        load_frames();
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        tick(GAP_BITS * BIT_CLKS);      // first idle period arms the receiver
        for (e = 0; e < NUM_ENTRIES; e++)
            run_entry(e);
        drain_held();
        tick(4);
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run hung and did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- cdbus_rx.f
hw/cdbus_rx_pkg.sv
hw/cdbus_rx_ifs.sv
hw/rx_des.sv
hw/rx_bytes.sv
hw/rx_pp_ram.sv
hw/cdbus_rx.sv
tb/cdbus_rx_checker.sv
tb/tb_cdbus_rx.sv
